// File: vlog.f
+incdir+verilog
verilog/corePkg.sv
verilog/aluCore.sv
verilog/controlDecode.sv
verilog/instrFetch.sv
verilog/fetchBuffer.sv
verilog/execUnit.sv
verilog/coreTop.sv
verif/clockGen.sv
verif/core_sva.sv
verif/coreTb.sv

// File: verif/coreTb.sv
/* Core testbench */
`timescale 1ns/1ns
`include "core_config.svh"

module coreTb;

    localparam int progLen     = 26;
    localparam int numEvents   = 17;
    localparam int numTests    = 5;
    localparam int drainCycles = 8;
    localparam int clkPeriod   = 100;

    typedef struct packed {
        logic [2:0]  test;
        logic        isStore;
        logic [31:0] addr;
        logic [31:0] data;
    } expEvent;

    logic                       clk;
    logic                       rstN;
    logic                       imemLoad;
    logic [`IMEM_ADDR_BITS-1:0] imemLoadAddr;
    corePkg::instrWord          imemLoadData;
    corePkg::regWriteback       wbOut;
    corePkg::storeRequest       storeOut;
    logic                       illegalOp;

    corePkg::instrWord progTable [progLen];
    expEvent           expTable [numEvents];
    string             testNames [numTests];

    int   errCount;
    int   evIdx;
    int   illegalCount;
    int   testErrStart;
    logic prevRedirect;
    logic resetDone;

    clockGen #(.period(clkPeriod)) clkGen (.clk(clk));

    coreTop u_dut (
        .clk          (clk),
        .rstN         (rstN),
        .imemLoad     (imemLoad),
        .imemLoadAddr (imemLoadAddr),
        .imemLoadData (imemLoadData),
        .wbOut        (wbOut),
        .storeOut     (storeOut),
        .illegalOp    (illegalOp)
    );

    function automatic corePkg::instrWord encodeImm(corePkg::opCode op, logic [4:0] rs,
                                                    logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic corePkg::instrWord encodeReg(logic [4:0] rs, logic [4:0] rt,
                                                    logic [4:0] rd, corePkg::functCode fn);
        return {corePkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic corePkg::instrWord encodeJump(corePkg::opCode op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic fillTables();
        progTable[0]  = encodeImm(corePkg::OP_XORI, 0, 1, 16'h0005);
        progTable[1]  = encodeImm(corePkg::OP_XORI, 0, 2, 16'h0003);
        progTable[2]  = encodeReg(1, 2, 3, corePkg::FN_ADD);
        progTable[3]  = encodeReg(2, 1, 4, corePkg::FN_SUB);   // 3 - 5
        progTable[4]  = encodeReg(4, 1, 5, corePkg::FN_SLT);   // -2 < 5
        progTable[5]  = encodeReg(1, 4, 6, corePkg::FN_SLT);
        progTable[6]  = encodeImm(corePkg::OP_XORI, 0, 7, 16'h8001);  // Zero-extended
        progTable[7]  = encodeImm(corePkg::OP_XORI, 0, 8, 16'h0010);
        progTable[8]  = encodeImm(corePkg::OP_SW, 8, 4, 16'h0008);
        progTable[9]  = encodeImm(corePkg::OP_SW, 8, 3, 16'hFFFC);    // Offset -4
        progTable[10] = encodeImm(corePkg::OP_LW, 8, 9, 16'h0008);
        progTable[11] = encodeImm(corePkg::OP_LW, 8, 10, 16'hFFFC);
        progTable[12] = encodeImm(corePkg::OP_BNE, 1, 2, 16'h0001);   // Taken
        progTable[13] = encodeImm(corePkg::OP_XORI, 0, 11, 16'h0BAD);
        progTable[14] = encodeImm(corePkg::OP_BNE, 3, 10, 16'h0001);  // Equal operands fall through
        progTable[15] = encodeImm(corePkg::OP_XORI, 0, 12, 16'h0012);
        progTable[16] = encodeJump(corePkg::OP_JAL, 26'd20);
        progTable[17] = encodeImm(corePkg::OP_XORI, 0, 13, 16'h0077);
        progTable[18] = encodeJump(corePkg::OP_J, 26'd22);
        progTable[19] = encodeImm(corePkg::OP_XORI, 0, 14, 16'h0BAD);
        progTable[20] = encodeImm(corePkg::OP_XORI, 0, 15, 16'h0055);  // Subroutine
        progTable[21] = encodeReg(31, 0, 0, corePkg::FN_JR);
        progTable[22] = 32'hFC00_0000;                                // Opcode 63
        progTable[23] = encodeReg(1, 2, 0, corePkg::FN_ADD);
        progTable[24] = encodeReg(0, 0, 16, corePkg::FN_ADD);
        progTable[25] = encodeJump(corePkg::OP_J, 26'd25);            // Halt loop

        // Test, store flag, register or byte address, data
        expTable[0]  = '{3'd1, 1'b0, 32'd1, 32'h0000_0005};
        expTable[1]  = '{3'd1, 1'b0, 32'd2, 32'h0000_0003};
        expTable[2]  = '{3'd1, 1'b0, 32'd3, 32'h0000_0008};
        expTable[3]  = '{3'd1, 1'b0, 32'd4, 32'hFFFF_FFFE};
        expTable[4]  = '{3'd1, 1'b0, 32'd5, 32'h0000_0001};
        expTable[5]  = '{3'd1, 1'b0, 32'd6, 32'h0000_0000};
        expTable[6]  = '{3'd1, 1'b0, 32'd7, 32'h0000_8001};
        expTable[7]  = '{3'd2, 1'b0, 32'd8, 32'h0000_0010};
        expTable[8]  = '{3'd2, 1'b1, 32'd24, 32'hFFFF_FFFE};
        expTable[9]  = '{3'd2, 1'b1, 32'd12, 32'h0000_0008};
        expTable[10] = '{3'd2, 1'b0, 32'd9, 32'hFFFF_FFFE};
        expTable[11] = '{3'd2, 1'b0, 32'd10, 32'h0000_0008};
        expTable[12] = '{3'd3, 1'b0, 32'd12, 32'h0000_0012};
        expTable[13] = '{3'd4, 1'b0, 32'd31, 32'h0000_0044};  // Link is 64 + 4
        expTable[14] = '{3'd4, 1'b0, 32'd15, 32'h0000_0055};
        expTable[15] = '{3'd4, 1'b0, 32'd13, 32'h0000_0077};
        expTable[16] = '{3'd5, 1'b0, 32'd16, 32'h0000_0000};

        testNames = '{"arithmetic", "memory", "branches", "jumps", "illegal and r0"};
    endtask

    task automatic checkValue(logic [31:0] got, logic [31:0] want, string what);
        if (got !== want) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, want);
            errCount++;
        end
    endtask

    task automatic finishTest(int t);
        if (t == 5) begin
            checkValue(illegalCount, 1, "illegalOp pulse count");
        end
        $display("Test %0d %s: %s", t, testNames[t-1],
                 (errCount == testErrStart) ? "ok" : "mismatches");
        testErrStart = errCount;
    endtask

    task automatic matchEvent(logic isStore, logic [31:0] addr, logic [31:0] data);
        expEvent want;
        if (evIdx >= numEvents) begin
            $display("Unexpected extra %s event at %0t, addr %h data %h",
                     isStore ? "store" : "writeback", $time, addr, data);
            errCount++;
            return;
        end
        want = expTable[evIdx];
        checkValue(isStore, want.isStore, $sformatf("event %0d kind", evIdx));
        checkValue(addr, want.addr, $sformatf("event %0d addr", evIdx));
        checkValue(data, want.data, $sformatf("event %0d data", evIdx));
        evIdx++;
        if (evIdx == numEvents || expTable[evIdx].test != want.test) begin
            finishTest(want.test);
        end
    endtask

    // Outputs are sampled mid-cycle
    task automatic observeCycle();
        @(negedge clk);
        if (prevRedirect) begin
            checkValue(u_dut.bufPkt.valid, 0, "buffer valid after redirect");
        end
        prevRedirect = u_dut.redirect;
        checkValue(wbOut.valid && storeOut.valid, 0, "writeback and store together");
        if (illegalOp) begin
            illegalCount++;
        end
        if (wbOut.valid) begin
            matchEvent(1'b0, 32'(wbOut.addr), wbOut.data);
        end
        if (storeOut.valid) begin
            matchEvent(1'b1, storeOut.addr, storeOut.data);
        end
    endtask

    initial begin
        errCount     = 0;
        evIdx        = 0;
        illegalCount = 0;
        testErrStart = 0;
        prevRedirect = 1'b0;
        resetDone    = 1'b0;
        rstN         = 1'b0;
        imemLoad     = 1'b0;
        imemLoadAddr = '0;
        imemLoadData = '0;
        fillTables();

        // Words past the program jump to themselves
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            @(posedge clk);
            #5;
            imemLoad     = 1'b1;
            imemLoadAddr = i[`IMEM_ADDR_BITS-1:0];
            imemLoadData = (i < progLen) ? progTable[i] : encodeJump(corePkg::OP_J, i[25:0]);
        end
        @(posedge clk);
        #5;
        imemLoad = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rstN      = 1'b1;
        resetDone = 1'b1;

        while (evIdx < numEvents) begin
            observeCycle();
        end
        repeat (drainCycles) observeCycle();   // Nothing more may show up

        $display("Summary: %0d of %0d events seen, %0d errors", evIdx, numEvents, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (resetDone);
        #((progLen * 4 + 10) * clkPeriod);
        $display("Timeout: the program did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

// File: verif/core_sva.sv
/* Core assertions */
`timescale 1ns/1ns

module core_sva (
    input logic                 clk,
    input logic                 rstN,
    input logic                 redirect,
    input logic                 bufValid,
    input corePkg::regWriteback wbOut,
    input corePkg::storeRequest storeOut
);

    // Wrong-path instruction must be squashed
    flushAfterRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirect |=> !bufValid)
        else $error("fetch buffer still valid in the cycle after a redirect");

    oneEventPerCycle: assert property (@(posedge clk) disable iff (!rstN)
        !(wbOut.valid && storeOut.valid))
        else $error("writeback and store valid in the same cycle");

    noRegZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.valid |-> (wbOut.addr != '0))
        else $error("writeback to register 0 reported");

endmodule

bind coreTop core_sva sva (
    .clk      (clk),
    .rstN     (rstN),
    .redirect (redirect),
    .bufValid (bufPkt.valid),
    .wbOut    (wbOut),
    .storeOut (storeOut)
);

// File: verif/clockGen.sv
/* Testbench clock */
`timescale 1ns/1ns

module clockGen #(
    parameter int period = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

// File: verilog/coreTop.sv
/* Core top level */
`timescale 1ns/1ns
`include "core_config.svh"

module coreTop (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        imemLoad,
    input  logic [`IMEM_ADDR_BITS-1:0]  imemLoadAddr,
    input  corePkg::instrWord           imemLoadData,
    output corePkg::regWriteback        wbOut,
    output corePkg::storeRequest        storeOut,
    output logic                        illegalOp
);

    corePkg::fetchPacket fetchPkt;
    corePkg::fetchPacket bufPkt;
    logic                redirect;
    corePkg::dataWord    redirectPc;

    instrFetch fetch (
        .clk          (clk),
        .rstN         (rstN),
        .imemLoad     (imemLoad),
        .imemLoadAddr (imemLoadAddr),
        .imemLoadData (imemLoadData),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .fetchOut     (fetchPkt)
    );

    fetchBuffer buffer (
        .clk       (clk),
        .rstN      (rstN),
        .fetchIn   (fetchPkt),
        .redirect  (redirect),
        .decodeOut (bufPkt)
    );

    // Redirect goes back to both fetch and buffer
    execUnit exec (
        .clk        (clk),
        .rstN       (rstN),
        .instIn     (bufPkt),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbOut      (wbOut),
        .storeOut   (storeOut),
        .illegalOp  (illegalOp)
    );

endmodule

// File: verilog/execUnit.sv
/* Execute stage */
`timescale 1ns/1ns
`include "core_config.svh"

module execUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  corePkg::fetchPacket  instIn,
    output logic                 redirect,
    output corePkg::dataWord     redirectPc,
    output corePkg::regWriteback wbOut,
    output corePkg::storeRequest storeOut,
    output logic                 illegalOp
);

    corePkg::dataWord   regFile [`REG_COUNT];
    corePkg::dataWord   dmem [`DMEM_DEPTH];

    corePkg::instrWord  instr;
    corePkg::opCode     opcode;
    corePkg::ctrlBundle ctrl;
    corePkg::regAddr    rs;
    corePkg::regAddr    rt;
    corePkg::regAddr    rd;
    corePkg::regAddr    destAddr;
    corePkg::dataWord   rsVal;
    corePkg::dataWord   rtVal;
    corePkg::dataWord   immExt;
    corePkg::dataWord   aluB;
    corePkg::dataWord   aluResult;
    corePkg::dataWord   memRead;
    corePkg::dataWord   wbData;
    corePkg::dataWord   pcPlus4;
    logic               aluZero;
    logic               branchTaken;

    assign instr  = instIn.instr;
    assign opcode = corePkg::opCode'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    controlDecode decode (
        .opcode (opcode),
        .funct  (corePkg::functCode'(instr[5:0])),
        .ctrl   (ctrl)
    );

    assign rsVal = regFile[rs];
    assign rtVal = regFile[rt];

    // XORI takes a zero-extended immediate, the rest sign-extend
    assign immExt = (opcode == corePkg::OP_XORI) ?
                    {{(`DATA_WIDTH-16){1'b0}}, instr[15:0]} :
                    {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
    assign aluB   = ctrl.useRegB ? rtVal : immExt;

    aluCore alu (
        .op     (ctrl.aluCmd),
        .a      (rsVal),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign memRead = dmem[aluResult[`DMEM_ADDR_BITS+1:2]];
    assign pcPlus4 = instIn.pc + corePkg::dataWord'(4);

    always_comb begin
        case (ctrl.dest)
            corePkg::DEST_RD:   destAddr = rd;
            corePkg::DEST_LINK: destAddr = corePkg::regAddr'(`LINK_REG);
            default:            destAddr = rt;
        endcase
        case (ctrl.wbSrc)
            corePkg::WB_MEM:    wbData = memRead;
            corePkg::WB_LINKPC: wbData = pcPlus4;
            default:            wbData = aluResult;
        endcase
    end

    // Register 0 stays zero and never shows up as a writeback
    assign wbOut = '{valid: instIn.valid && ctrl.regWrite && (destAddr != '0),
                     addr: destAddr, data: wbData};
    assign storeOut = '{valid: instIn.valid && ctrl.memWrite, addr: aluResult, data: rtVal};
    assign illegalOp = instIn.valid && ctrl.illegal;

    assign branchTaken = ctrl.branch && !aluZero;  // BNE
    assign redirect    = instIn.valid && (branchTaken || ctrl.jumpAbs);

    always_comb begin
        if (ctrl.jumpReg) begin
            redirectPc = rsVal;
        end else if (ctrl.jumpAbs) begin
            redirectPc = {pcPlus4[`DATA_WIDTH-1:`DATA_WIDTH-4], instr[25:0], 2'b00};
        end else begin
            redirectPc = pcPlus4 + {immExt[`DATA_WIDTH-3:0], 2'b00};  // Word offset
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbOut.valid) begin
            regFile[wbOut.addr] <= wbOut.data;
        end
    end

    always_ff @(posedge clk) begin
        if (storeOut.valid) begin
            dmem[aluResult[`DMEM_ADDR_BITS+1:2]] <= storeOut.data;
        end
    end

endmodule

// File: verilog/fetchBuffer.sv
/* Fetch buffer */
`timescale 1ns/1ns

module fetchBuffer (
    input  logic                clk,
    input  logic                rstN,
    input  corePkg::fetchPacket fetchIn,
    input  logic                redirect,
    output corePkg::fetchPacket decodeOut
);

    logic              bufValid;
    corePkg::dataWord  bufPc;
    corePkg::instrWord bufInstr;

    // Redirect kills the wrong-path instruction
    always_ff @(posedge clk) begin
        if (!rstN || redirect) begin
            bufValid <= 1'b0;
        end else begin
            bufValid <= fetchIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        bufPc    <= fetchIn.pc;
        bufInstr <= fetchIn.instr;
    end

    assign decodeOut = '{valid: bufValid, pc: bufPc, instr: bufInstr};

endmodule

// File: verilog/instrFetch.sv
/* Instruction fetch */
`timescale 1ns/1ns
`include "core_config.svh"

module instrFetch (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        imemLoad,
    input  logic [`IMEM_ADDR_BITS-1:0]  imemLoadAddr,
    input  corePkg::instrWord           imemLoadData,
    input  logic                        redirect,
    input  corePkg::dataWord            redirectPc,
    output corePkg::fetchPacket         fetchOut
);

    corePkg::dataWord  pc;
    corePkg::instrWord imem [`IMEM_DEPTH];

    // Load port, used by the testbench while the core is held in reset
    always_ff @(posedge clk) begin
        if (imemLoad) begin
            imem[imemLoadAddr] <= imemLoadData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= corePkg::dataWord'(`RESET_PC);
        end else if (redirect) begin
            pc <= redirectPc;  // Taken branch or jump
        end else begin
            pc <= pc + corePkg::dataWord'(4);
        end
    end

    // Fetch runs every cycle; the buffer squashes anything caught in reset
    always_comb begin
        fetchOut.valid = 1'b1;
        fetchOut.pc    = pc;
        fetchOut.instr = imem[pc[`IMEM_ADDR_BITS+1:2]];  // Word addressed
    end

endmodule

// File: verilog/controlDecode.sv
/* Control lookup */
`timescale 1ns/1ns

module controlDecode (
    input  corePkg::opCode     opcode,
    input  corePkg::functCode  funct,
    output corePkg::ctrlBundle ctrl
);

    corePkg::ctrlBundle opCtrl;
    corePkg::ctrlBundle rCtrl;

    // All controls off and flagged illegal
    localparam corePkg::ctrlBundle idleCtrl = '{
        regWrite: 1'b0, memWrite: 1'b0, dest: corePkg::DEST_RT, useRegB: 1'b0,
        aluCmd: corePkg::ALU_ADD, wbSrc: corePkg::WB_ALU,
        jumpReg: 1'b0, jumpAbs: 1'b0, branch: 1'b0, illegal: 1'b1
    };

    // I and J type table
    always_comb begin
        opCtrl = idleCtrl;
        opCtrl.illegal = 1'b0;
        case (opcode)
            corePkg::OP_BNE: begin
                opCtrl.useRegB = 1'b1;
                opCtrl.aluCmd  = corePkg::ALU_SUB;  // Compare by subtraction
                opCtrl.branch  = 1'b1;
            end
            corePkg::OP_LW: begin
                opCtrl.regWrite = 1'b1;
                opCtrl.wbSrc    = corePkg::WB_MEM;
            end
            corePkg::OP_SW: opCtrl.memWrite = 1'b1;
            corePkg::OP_J:  opCtrl.jumpAbs  = 1'b1;
            corePkg::OP_JAL: begin
                opCtrl.regWrite = 1'b1;
                opCtrl.dest     = corePkg::DEST_LINK;
                opCtrl.wbSrc    = corePkg::WB_LINKPC;
                opCtrl.jumpAbs  = 1'b1;
            end
            corePkg::OP_XORI: begin
                opCtrl.regWrite = 1'b1;
                opCtrl.aluCmd   = corePkg::ALU_XOR;
            end
            default: opCtrl = idleCtrl;
        endcase
    end

    // R type table, keyed on funct
    always_comb begin
        rCtrl = idleCtrl;
        rCtrl.illegal = 1'b0;
        case (funct)
            corePkg::FN_JR: begin
                rCtrl.jumpReg = 1'b1;
                rCtrl.jumpAbs = 1'b1;
            end
            corePkg::FN_ADD, corePkg::FN_SUB, corePkg::FN_SLT: begin
                rCtrl.regWrite = 1'b1;
                rCtrl.dest     = corePkg::DEST_RD;
                rCtrl.useRegB  = 1'b1;
                rCtrl.aluCmd   = (funct == corePkg::FN_ADD) ? corePkg::ALU_ADD :
                                 (funct == corePkg::FN_SUB) ? corePkg::ALU_SUB :
                                                              corePkg::ALU_SLT;
            end
            default: rCtrl = idleCtrl;
        endcase
    end

    assign ctrl = (opcode == corePkg::OP_RTYPE) ? rCtrl : opCtrl;

endmodule

// File: verilog/aluCore.sv
/* ALU */
`timescale 1ns/1ns

module aluCore (
    input  corePkg::aluOp    op,
    input  corePkg::dataWord a,
    input  corePkg::dataWord b,
    output corePkg::dataWord result,
    output logic             zero
);

    always_comb begin
        case (op)
            corePkg::ALU_ADD:  result = a + b;
            corePkg::ALU_SUB:  result = a - b;
            corePkg::ALU_XOR:  result = a ^ b;
            corePkg::ALU_SLT:  result = corePkg::dataWord'($signed(a) < $signed(b));  // Signed
            corePkg::ALU_AND:  result = a & b;
            corePkg::ALU_NAND: result = ~(a & b);
            corePkg::ALU_NOR:  result = ~(a | b);
            corePkg::ALU_OR:   result = a | b;
            default:           result = '0;
        endcase
    end

    // BNE takes the branch when this is low
    assign zero = (result == '0);

endmodule

// File: verilog/corePkg.sv
/* Core types */
`include "core_config.svh"

package corePkg;

    typedef logic [`DATA_WIDTH-1:0]        dataWord;
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddr;
    typedef logic [31:0]                   instrWord;

    // Primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_JAL   = 6'd3,
        OP_BNE   = 6'd5,
        OP_XORI  = 6'd14,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opCode;

    typedef enum logic [5:0] {
        FN_JR  = 6'd8,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_SLT = 6'd42
    } functCode;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLT, ALU_AND, ALU_NAND, ALU_NOR, ALU_OR
    } aluOp;

    typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_LINK} destSel;

    typedef enum logic [1:0] {WB_MEM, WB_ALU, WB_LINKPC} wbSel;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        destSel dest;
        logic   useRegB;   // Operand b from rt, else immediate
        aluOp   aluCmd;
        wbSel   wbSrc;
        logic   jumpReg;
        logic   jumpAbs;
        logic   branch;
        logic   illegal;
    } ctrlBundle;

    typedef struct packed {
        logic     valid;
        dataWord  pc;
        instrWord instr;
    } fetchPacket;

    typedef struct packed {
        logic    valid;
        regAddr  addr;
        dataWord data;
    } regWriteback;

    typedef struct packed {
        logic    valid;
        dataWord addr;
        dataWord data;
    } storeRequest;

endpackage

// File: verilog/core_config.svh
/* Core configuration */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define DATA_WIDTH     32  // Register and memory word
`define REG_COUNT      32

`define IMEM_DEPTH     64  // Instruction words
`define IMEM_ADDR_BITS 6
`define DMEM_DEPTH     64
`define DMEM_ADDR_BITS 6

// First instruction fetched after reset
`define RESET_PC       0

`define LINK_REG       31  // JAL destination

`endif
